// File: rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int ADDR_W = 6;
    localparam int DATA_W = 16;
    localparam int REG_W  = 3;   // Registers live at mem[0..7]

    // First instruction sits just past the register words
    localparam logic [ADDR_W-1:0] PROG_START = 6'd8;

    // Opcodes, instr[15:12]
    localparam logic [3:0] OP_MOV  = 4'd0;
    localparam logic [3:0] OP_ADD  = 4'd1;
    localparam logic [3:0] OP_SUB  = 4'd2;
    localparam logic [3:0] OP_MUL  = 4'd3;
    localparam logic [3:0] OP_DIV  = 4'd4;
    localparam logic [3:0] OP_IN   = 4'd7;
    localparam logic [3:0] OP_OUT  = 4'd8;
    localparam logic [3:0] OP_STOP = 4'd15;

    // ALU codes, opcode minus one for the arithmetic group
    localparam logic [1:0] ALU_ADD = 2'd0;
    localparam logic [1:0] ALU_SUB = 2'd1;
    localparam logic [1:0] ALU_MUL = 2'd2;
    localparam logic [1:0] ALU_DIV = 2'd3;

    localparam logic [DATA_W-1:0] DIV_ZERO_RESULT = 16'hffff;

endpackage

// File: rtl/mem_if.sv
interface mem_if;
    import cpu_pkg::*;

    logic              req;     // Held until gnt
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              gnt;     // One cycle, access done
    logic [DATA_W-1:0] rdata;   // Valid while gnt is high

    modport client (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

// File: rtl/mem_arbiter.sv
module mem_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    mem_if.arbiter                       f_port,
    mem_if.arbiter                       o_port,
    mem_if.arbiter                       e_port,
    input  logic [cpu_pkg::DATA_W-1:0]   mem_rdata,
    output logic                         we,
    output logic [cpu_pkg::ADDR_W-1:0]   addr,
    output logic [cpu_pkg::DATA_W-1:0]   data
);
    import cpu_pkg::*;

    logic [2:0] gnt_q;   // One-hot owner of the access in flight
    logic [2:0] pick;

    // Fixed priority, fetch first; nothing new while an access is in flight
    always_comb begin
        pick = 3'b000;
        if (gnt_q == 3'b000) begin
            if (f_port.req) begin
                pick = 3'b001;
            end else if (o_port.req) begin
                pick = 3'b010;
            end else if (e_port.req) begin
                pick = 3'b100;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q <= 3'b000;
            we    <= 1'b0;
            addr  <= '0;
            data  <= '0;
        end else begin
            gnt_q <= pick;
            we    <= 1'b0;   // Write strobe lasts one cycle
            if (pick[0]) begin
                we   <= f_port.we;
                addr <= f_port.addr;
                data <= f_port.wdata;
            end else if (pick[1]) begin
                we   <= o_port.we;
                addr <= o_port.addr;
                data <= o_port.wdata;
            end else if (pick[2]) begin
                we   <= e_port.we;
                addr <= e_port.addr;
                data <= e_port.wdata;
            end
        end
    end

    // Bus address is stable this cycle, so memory data passes straight through
    assign f_port.gnt   = gnt_q[0];
    assign o_port.gnt   = gnt_q[1];
    assign e_port.gnt   = gnt_q[2];
    assign f_port.rdata = gnt_q[0] ? mem_rdata : '0;
    assign o_port.rdata = gnt_q[1] ? mem_rdata : '0;
    assign e_port.rdata = gnt_q[2] ? mem_rdata : '0;

endmodule

// File: rtl/fetch_unit.sv
module fetch_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    mem_if.client                        mem,
    output logic [cpu_pkg::DATA_W-1:0]   instr,
    output logic [cpu_pkg::ADDR_W-1:0]   pc,
    output logic                         done
);
    import cpu_pkg::*;

    logic booted;   // Low only in the first cycle after reset
    logic go;
    logic req;

    assign go = start | ~booted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            booted <= 1'b0;
            req    <= 1'b0;
            pc     <= PROG_START;
            done   <= 1'b0;
        end else begin
            booted <= 1'b1;
            done   <= 1'b0;
            if (go) begin
                req <= 1'b1;
            end else if (mem.gnt) begin
                req  <= 1'b0;
                pc   <= pc + 1'b1;
                done <= 1'b1;   // IR and PC both valid with done
            end
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (mem.gnt) begin
            instr <= mem.rdata;
        end
    end

    // Read only
    assign mem.req   = req;
    assign mem.we    = 1'b0;
    assign mem.addr  = pc;
    assign mem.wdata = '0;

endmodule

// File: rtl/operand_unit.sv
module operand_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [cpu_pkg::DATA_W-1:0]   instr,
    mem_if.client                        mem,
    output logic [cpu_pkg::DATA_W-1:0]   val_x,
    output logic [cpu_pkg::DATA_W-1:0]   val_y,
    output logic [cpu_pkg::DATA_W-1:0]   val_z,
    output logic [cpu_pkg::ADDR_W-1:0]   dest_x,
    output logic                         done
);
    import cpu_pkg::*;

    logic              active;   // Walking the operand list
    logic              req;
    logic              ptr;      // Second read of an indirect operand
    logic [1:0]        idx;      // 0 = X, 1 = Y, 2 = Z
    logic [2:0]        used;     // Bit per operand, bit 0 is X
    logic [3:0]        fld;
    logic              use_cur;
    logic              last;
    logic [ADDR_W-1:0] reg_addr;
    logic [ADDR_W-1:0] addr_q;

    always_comb begin
        case (instr[15:12])
            OP_MOV:                         used = 3'b011;
            OP_ADD, OP_SUB, OP_MUL, OP_DIV: used = 3'b111;
            OP_IN, OP_OUT:                  used = 3'b001;
            default:                        used = 3'b000;
        endcase
    end

    // Current operand field
    always_comb begin
        case (idx)
            2'd0: begin
                fld     = instr[11:8];
                use_cur = used[0];
            end
            2'd1: begin
                fld     = instr[7:4];
                use_cur = used[1];
            end
            default: begin
                fld     = instr[3:0];
                use_cur = used[2];
            end
        endcase
    end

    assign last     = (idx == 2'd2);
    assign reg_addr = {{(ADDR_W-REG_W){1'b0}}, fld[REG_W-1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            req    <= 1'b0;
            ptr    <= 1'b0;
            idx    <= 2'd0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
                idx    <= 2'd0;
            end else if (active && !req) begin
                if (use_cur) begin
                    req <= 1'b1;
                end else if (last) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    idx <= idx + 2'd1;   // Skip unused operand
                end
            end else if (mem.gnt) begin
                if (fld[3] && !ptr) begin
                    ptr <= 1'b1;         // Keep req up for the pointer read
                end else begin
                    req <= 1'b0;
                    ptr <= 1'b0;
                    if (last) begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end else begin
                        idx <= idx + 2'd1;
                    end
                end
            end
        end
    end

    // Address and operand holding
    always_ff @(posedge clk) begin
        if (active && !req && use_cur) begin
            addr_q <= reg_addr;
            if (idx == 2'd0) begin
                dest_x <= reg_addr;
            end
        end
        if (mem.gnt) begin
            if (fld[3] && !ptr) begin
                addr_q <= mem.rdata[ADDR_W-1:0];
                if (idx == 2'd0) begin
                    dest_x <= mem.rdata[ADDR_W-1:0];   // Write goes through the pointer
                end
            end else begin
                case (idx)
                    2'd0:    val_x <= mem.rdata;
                    2'd1:    val_y <= mem.rdata;
                    default: val_z <= mem.rdata;
                endcase
            end
        end
    end

    assign mem.req   = req;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

endmodule

// File: rtl/alu.sv
module alu (
    input  logic [1:0]                   op,
    input  logic [cpu_pkg::DATA_W-1:0]   a,
    input  logic [cpu_pkg::DATA_W-1:0]   b,
    output logic [cpu_pkg::DATA_W-1:0]   f
);
    import cpu_pkg::*;

    logic [2*DATA_W-1:0] prod;

    assign prod = a * b;

    always_comb begin
        case (op)
            ALU_ADD: f = a + b;
            ALU_SUB: f = a - b;
            ALU_MUL: f = prod[DATA_W-1:0];   // Low half only
            ALU_DIV: begin
                if (b == '0) begin
                    f = DIV_ZERO_RESULT;
                end else begin
                    f = a / b;             // Unsigned
                end
            end
        endcase
    end

endmodule

// File: rtl/exec_unit.sv
module exec_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [cpu_pkg::DATA_W-1:0]   instr,
    input  logic [cpu_pkg::DATA_W-1:0]   val_x,
    input  logic [cpu_pkg::DATA_W-1:0]   val_y,
    input  logic [cpu_pkg::DATA_W-1:0]   val_z,
    input  logic [cpu_pkg::ADDR_W-1:0]   dest_x,
    input  logic [cpu_pkg::DATA_W-1:0]   in_data,
    mem_if.client                        mem,
    output logic [cpu_pkg::DATA_W-1:0]   out_data,
    output logic                         status,
    output logic                         done
);
    import cpu_pkg::*;

    logic [3:0]        op;
    logic [1:0]        alu_op;
    logic [DATA_W-1:0] alu_f;
    logic [DATA_W-1:0] result;
    logic              is_write;
    logic              req;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;

    assign op     = instr[15:12];
    assign alu_op = op[1:0] - OP_ADD[1:0];

    alu u_alu (
        .op (alu_op),
        .a  (val_y),
        .b  (val_z),
        .f  (alu_f)
    );

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_IN: is_write = 1'b1;
            OP_MOV:  is_write = (instr[3:0] == 4'd0);   // Z must be zero
            default: is_write = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            OP_MOV:  result = val_y;
            OP_IN:   result = in_data;   // Port sampled at start
            default: result = alu_f;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req      <= 1'b0;
            out_data <= '0;
            status   <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                if (is_write) begin
                    req <= 1'b1;
                end else if (op == OP_OUT) begin
                    out_data <= val_x;
                    done     <= 1'b1;
                end else if (op == OP_STOP) begin
                    status <= 1'b1;   // No done, so fetch never restarts
                end else begin
                    done <= 1'b1;
                end
            end else if (mem.gnt) begin
                req  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= dest_x;
            wdata_q <= result;
        end
    end

    assign mem.req   = req;
    assign mem.we    = 1'b1;   // Only ever writes
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

endmodule

// File: rtl/cpu_top.sv
module cpu_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [cpu_pkg::DATA_W-1:0]   mem_rdata,
    input  logic [cpu_pkg::DATA_W-1:0]   in_data,
    output logic                         status,
    output logic                         we,
    output logic [cpu_pkg::ADDR_W-1:0]   addr,
    output logic [cpu_pkg::DATA_W-1:0]   data,
    output logic [cpu_pkg::DATA_W-1:0]   out_data,
    output logic [cpu_pkg::ADDR_W-1:0]   pc
);
    import cpu_pkg::*;

    logic              fetch_done;
    logic              operand_done;
    logic              exec_done;
    logic [DATA_W-1:0] instr;
    logic [DATA_W-1:0] val_x;
    logic [DATA_W-1:0] val_y;
    logic [DATA_W-1:0] val_z;
    logic [ADDR_W-1:0] dest_x;

    // One memory path per unit
    mem_if f_bus ();
    mem_if o_bus ();
    mem_if e_bus ();

    fetch_unit u_fetch (
        .clk   (clk),
        .rst_n (rst_n),
        .start (exec_done),
        .mem   (f_bus),
        .instr (instr),
        .pc    (pc),
        .done  (fetch_done)
    );

    operand_unit u_operand (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (fetch_done),
        .instr  (instr),
        .mem    (o_bus),
        .val_x  (val_x),
        .val_y  (val_y),
        .val_z  (val_z),
        .dest_x (dest_x),
        .done   (operand_done)
    );

    exec_unit u_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (operand_done),
        .instr    (instr),
        .val_x    (val_x),
        .val_y    (val_y),
        .val_z    (val_z),
        .dest_x   (dest_x),
        .in_data  (in_data),
        .mem      (e_bus),
        .out_data (out_data),
        .status   (status),
        .done     (exec_done)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .f_port    (f_bus),
        .o_port    (o_bus),
        .e_port    (e_bus),
        .mem_rdata (mem_rdata),
        .we        (we),
        .addr      (addr),
        .data      (data)
    );

endmodule

// File: dv/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // Period 100
    end

    // Reset held for 5 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: dv/tb_cpu.sv
module tb_cpu;
    import cpu_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h8af1;

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] mem_rdata;
    logic [DATA_W-1:0] in_data;
    logic              status;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] out_data;
    logic [ADDR_W-1:0] pc;

    logic [DATA_W-1:0] mem [0:63];       // Memory seen by the DUT
    logic [DATA_W-1:0] exp_mem [0:63];   // Reference model copy
    logic [DATA_W-1:0] in_table [0:31];  // in_data per instruction slot
    logic [DATA_W-1:0] exp_out [$];
    logic [DATA_W-1:0] exp_changes [$];  // exp_out without repeats
    logic [DATA_W-1:0] last_out;
    logic [31:0]       lfsr_state;
    logic [ADDR_W-1:0] stop_pc;
    int                prog_len;
    int                out_idx;
    int                errors;
    int                cycles;
    int                max_cycles;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cpu_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .in_data   (in_data),
        .status    (status),
        .we        (we),
        .addr      (addr),
        .data      (data),
        .out_data  (out_data),
        .pc        (pc)
    );

    // Memory model
    assign mem_rdata = mem[addr];

    always @(posedge clk) begin
        if (we) begin
            mem[addr] = data;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    // Slot of the instruction whose fetch has completed
    function automatic int in_index(input logic [ADDR_W-1:0] p);
        if (p > PROG_START) begin
            return int'(p - PROG_START) - 1;
        end
        return 0;
    endfunction

    function automatic logic [ADDR_W-1:0] operand_addr(input logic [3:0] fld);
        if (fld[3]) begin
            return exp_mem[fld[2:0]][ADDR_W-1:0];   // Through the pointer
        end
        return {3'b000, fld[2:0]};
    endfunction

    function automatic logic [DATA_W-1:0] arith_ref(input logic [3:0] op,
                                                    input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;   // Low 16 bits
            OP_DIV:  return (b == 0) ? 16'hffff : a / b;
            default: return '0;
        endcase
    endfunction

    function automatic void cpu_model();
        logic [ADDR_W-1:0] pc_m;
        logic [DATA_W-1:0] ins;
        logic [ADDR_W-1:0] ax;
        logic [ADDR_W-1:0] ay;
        logic [ADDR_W-1:0] az;
        logic              halted;
        int                steps;
        pc_m   = PROG_START;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 64) begin
            ins = exp_mem[pc_m];
            ax  = operand_addr(ins[11:8]);
            ay  = operand_addr(ins[7:4]);
            az  = operand_addr(ins[3:0]);
            case (ins[15:12])
                OP_MOV: begin
                    if (ins[3:0] == 4'd0) begin
                        exp_mem[ax] = exp_mem[ay];
                    end
                end
                OP_ADD, OP_SUB, OP_MUL, OP_DIV: begin
                    exp_mem[ax] = arith_ref(ins[15:12], exp_mem[ay], exp_mem[az]);
                end
                OP_IN:   exp_mem[ax] = in_table[int'(pc_m - PROG_START)];
                OP_OUT:  exp_out.push_back(exp_mem[ax]);
                OP_STOP: halted = 1'b1;
                default: ;   // No-op
            endcase
            pc_m  = pc_m + 1'b1;
            steps = steps + 1;
        end
    endfunction

    task automatic put_instr(input logic [3:0] op, input logic [3:0] x,
                             input logic [3:0] y, input logic [3:0] z);
        mem[PROG_START + prog_len] = {op, x, y, z};
        prog_len = prog_len + 1;
    endtask

    // Fields 4'h0 to 4'h7 name rN directly and 4'h8 to 4'hf go through rN
    task automatic load_memory();
        for (int a = 0; a < 64; a++) begin
            mem[a] = rand_bits(16);
        end
        mem[3] = '0;   // Zero divisor for the first DIV
        for (int r = 4; r < 8; r++) begin
            mem[r] = 16'd40 + (rand_bits(5) % 24);   // Pointers into 40..63
        end
        for (int i = 0; i < 32; i++) begin
            in_table[i] = rand_bits(16);
        end
        prog_len = 0;
        put_instr(OP_DIV, 4'h0, 4'h1, 4'h3);   // Divide by zero
        put_instr(OP_ADD, 4'h1, 4'h2, 4'h0);
        put_instr(OP_SUB, 4'h2, 4'h1, 4'h0);
        put_instr(OP_MUL, 4'h0, 4'h1, 4'h2);
        put_instr(OP_DIV, 4'h1, 4'h2, 4'h4);   // Nonzero divisor
        put_instr(OP_ADD, 4'hc, 4'h0, 4'h1);   // Indirect X
        put_instr(OP_SUB, 4'h2, 4'hd, 4'h0);   // Indirect Y
        put_instr(OP_MUL, 4'h3, 4'h1, 4'he);   // Indirect Z
        put_instr(OP_DIV, 4'hf, 4'hc, 4'hd);
        put_instr(OP_MOV, 4'h0, 4'h1, 4'h0);
        put_instr(OP_MOV, 4'h1, 4'h2, 4'h5);   // Nonzero Z skips the write
        put_instr(4'd5, 4'h0, 4'h1, 4'h2);
        put_instr(4'd6, 4'h0, 4'h1, 4'h2);
        for (int k = 9; k <= 14; k++) begin
            put_instr(k[3:0], 4'h0, 4'h1, 4'h2);
        end
        put_instr(OP_IN, 4'h2, 4'h0, 4'h0);
        put_instr(OP_IN, 4'hf, 4'h0, 4'h0);
        put_instr(OP_OUT, 4'h2, 4'h0, 4'h0);
        put_instr(OP_OUT, 4'hf, 4'h0, 4'h0);
        put_instr(OP_OUT, 4'h0, 4'h0, 4'h0);
        put_instr(OP_MOV, 4'hd, 4'he, 4'h0);   // Pointer to pointer target
        put_instr(OP_OUT, 4'hd, 4'h0, 4'h0);
        put_instr(OP_STOP, 4'h0, 4'h0, 4'h0);
    endtask

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        errors = errors + 1;
    endtask

    task automatic check_reset_state(input string phase);
        if (we !== 1'b0) report_mismatch({phase, "_we"}, 16'd0, we);
        if (status !== 1'b0) report_mismatch({phase, "_status"}, 16'd0, status);
        if (out_data !== 16'd0) report_mismatch({phase, "_out_data"}, 16'd0, out_data);
        if (pc !== PROG_START) report_mismatch({phase, "_pc"}, PROG_START, pc);
        if (addr !== '0) report_mismatch({phase, "_addr"}, 16'd0, addr);
        if (data !== 16'd0) report_mismatch({phase, "_data"}, 16'd0, data);
    endtask

    // IN operand follows the instruction in flight
    always @(negedge clk) begin
        in_data = in_table[in_index(pc)];
    end

    // Each out_data change must match the next expected OUT value
    always @(negedge clk) begin
        if (rst_n && out_data !== last_out) begin
            if (out_idx >= exp_changes.size()) begin
                $display("out_data changed to %h with no OUT value left to expect", out_data);
                errors = errors + 1;
            end else if (out_data !== exp_changes[out_idx]) begin
                report_mismatch($sformatf("out_data[%0d]", out_idx),
                                exp_changes[out_idx], out_data);
            end
            out_idx  = out_idx + 1;
            last_out = out_data;
        end
    end

    initial begin
        in_data    = '0;
        errors     = 0;
        out_idx    = 0;
        last_out   = '0;
        lfsr_state = LFSR_SEED;
        load_memory();
        for (int a = 0; a < 64; a++) begin
            exp_mem[a] = mem[a];
        end
        cpu_model();
        foreach (exp_out[i]) begin
            if (exp_out[i] !== last_out) begin
                exp_changes.push_back(exp_out[i]);
            end
            last_out = exp_out[i];
        end
        last_out   = '0;
        max_cycles = prog_len * 30 + 50;

        @(posedge clk);   // First edge under reset
        @(negedge clk);
        check_reset_state("reset");
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_reset_state("after_reset");

        cycles = 0;
        while (status !== 1'b1 && cycles < max_cycles) begin
            @(negedge clk);
            cycles = cycles + 1;
        end

        if (status !== 1'b1) begin
            $display("CPU did not halt within %0d cycles", max_cycles);
            errors = errors + 1;
        end else begin
            stop_pc = pc;
            repeat (20) begin
                @(negedge clk);
                if (status !== 1'b1) begin
                    $display("status dropped after STOP at time %0t", $time);
                    errors = errors + 1;
                end
                if (pc !== stop_pc) report_mismatch("stop_pc", stop_pc, pc);
                if (we !== 1'b0) report_mismatch("stop_we", 16'd0, we);
            end
            for (int a = 0; a < 64; a++) begin
                if (mem[a] !== exp_mem[a]) begin
                    report_mismatch($sformatf("mem[%0d]", a), exp_mem[a], mem[a]);
                end
            end
            if (out_idx != exp_changes.size()) begin
                report_mismatch("out_count", exp_changes.size(), out_idx);
            end
        end

        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/cpu_pkg.sv
rtl/mem_if.sv
rtl/mem_arbiter.sv
rtl/fetch_unit.sv
rtl/operand_unit.sv
rtl/alu.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
dv/tb_clock.sv
dv/tb_cpu.sv
